// File: flist.f
+incdir+testbench
logic/pool_csr_pkg.sv
logic/pool_data_pkg.sv
logic/pool_csr.sv
logic/pool_line_buffer.sv
logic/window_average.sv
logic/pool_sequencer.sv
logic/avg_pool_top.sv
testbench/avg_pool_tb.sv

// File: logic/avg_pool_top.sv
// Average-pooling engine top level
// AXI4-Lite control port, AXI4-Stream pixel input and result output
`timescale 1ns/1ns
`default_nettype none

module avg_pool_top
    import pool_csr_pkg::*, pool_data_pkg::*;
#(
    parameter int KERNEL_SIZE = 3,
    parameter int CHANNELS    = 3,
    parameter int MAX_WIDTH   = 64
) (
    input  wire                       axi_clk,
    input  wire                       axi_reset_n,
    // AXI4-Lite control
    input  wire  [AXI_ADDR_WIDTH-1:0] awaddr,
    input  wire                       awvalid,
    output logic                      awready,
    input  wire  [AXI_DATA_WIDTH-1:0] wdata,
    input  wire                       wvalid,
    output logic                      wready,
    output logic                      bvalid,
    input  wire                       bready,
    input  wire  [AXI_ADDR_WIDTH-1:0] araddr,
    input  wire                       arvalid,
    output logic                      arready,
    output logic [AXI_DATA_WIDTH-1:0] rdata,
    output logic                      rvalid,
    input  wire                       rready,
    // AXI4-Stream pixels in, last unused since size comes from registers
    input  pixel_word_t               s_axis_data,
    input  wire                       s_axis_valid,
    output logic                      s_axis_ready,
    input  wire                       s_axis_last,
    // AXI4-Stream averages out
    output pixel_word_t               m_axis_data,
    output logic                      m_axis_valid,
    input  wire                       m_axis_ready,
    output logic                      m_axis_last,
    output logic [AXI_DATA_WIDTH/8-1:0] m_axis_keep
);

    localparam int X_W  = $clog2(MAX_WIDTH);
    localparam int CH_W = (CHANNELS > 1) ? $clog2(CHANNELS) : 1;

    pool_cfg_t         cfg;
    csr_word_u         csr_rdata;
    logic              pixel_write;
    logic [X_W-1:0]    x;
    logic [CH_W-1:0]   ch;
    logic              frame_clear;
    logic              window_ready;
    pixel_word_t       column [CHANNELS][KERNEL_SIZE];
    logic              column_valid;
    pixel_word_t       result [CHANNELS];
    logic              result_valid;
    stream_beat_t      out_beat;

    assign rdata       = csr_rdata.raw;
    assign m_axis_data = out_beat.data;
    assign m_axis_last = out_beat.last;
    assign m_axis_keep = '1;        // Every word is full

    pool_csr #(.KERNEL_SIZE(KERNEL_SIZE), .CHANNELS(CHANNELS)) pool_csr_i (
        .axi_clk, .axi_reset_n, .awaddr, .awvalid, .awready, .wdata, .wvalid,
        .wready, .bvalid, .bready, .araddr, .arvalid, .arready,
        .rdata(csr_rdata), .rvalid, .rready, .cfg
    );

    pool_sequencer #(.KERNEL_SIZE(KERNEL_SIZE), .CHANNELS(CHANNELS),
                     .MAX_WIDTH(MAX_WIDTH)) pool_sequencer_i (
        .axi_clk, .axi_reset_n, .cfg, .s_axis_valid, .s_axis_ready, .pixel_write,
        .x, .ch, .frame_clear, .window_ready, .result, .result_valid,
        .m_axis_valid, .m_axis_ready, .out_beat
    );

    pool_line_buffer #(.KERNEL_SIZE(KERNEL_SIZE), .CHANNELS(CHANNELS),
                       .MAX_WIDTH(MAX_WIDTH)) pool_line_buffer_i (
        .axi_clk, .axi_reset_n, .cfg, .pixel_write, .x, .ch, .data(s_axis_data),
        .frame_clear, .column, .column_valid
    );

    window_average #(.KERNEL_SIZE(KERNEL_SIZE), .CHANNELS(CHANNELS)) window_average_i (
        .axi_clk, .axi_reset_n, .column, .column_valid, .window_ready,
        .result, .result_valid
    );

endmodule

`default_nettype wire

// File: logic/pool_csr.sv
// AXI4-Lite slave holding the pooling control registers
// Takes single-beat writes and reads and drives the config to the datapath
`timescale 1ns/1ns
`default_nettype none

module pool_csr
    import pool_csr_pkg::*;
#(
    parameter int KERNEL_SIZE = 3,
    parameter int CHANNELS    = 3
) (
    input  wire                       axi_clk,
    input  wire                       axi_reset_n,
    input  wire  [AXI_ADDR_WIDTH-1:0] awaddr,
    input  wire                       awvalid,
    output logic                      awready,
    input  wire  [AXI_DATA_WIDTH-1:0] wdata,
    input  wire                       wvalid,
    output logic                      wready,
    output logic                      bvalid,
    input  wire                       bready,
    input  wire  [AXI_ADDR_WIDTH-1:0] araddr,
    input  wire                       arvalid,
    output logic                      arready,
    output csr_word_u                 rdata,
    output logic                      rvalid,
    input  wire                       rready,
    output pool_cfg_t                 cfg
);

    logic      wr_fire;     // Address and data taken together
    logic      ar_fire;
    logic      clear_pend;  // Soft clear lands one cycle later
    csr_word_u info_word;
    csr_word_u rd_word;

    // Address only accepted alongside its data
    assign awready = !bvalid && (!awvalid || wvalid);
    assign wready  = awvalid && !bvalid;
    assign wr_fire = awvalid && wvalid && !bvalid;
    assign arready = !rvalid;
    assign ar_fire = arvalid && !rvalid;

    // Constant identification word
    assign info_word.info = '{reserved: '0,
                              channels: 4'(CHANNELS),
                              kernel:   4'(KERNEL_SIZE),
                              key:      POOL_LAYER_KEY};

    // ------------------------------------------------------------
    // Read decode
    // ------------------------------------------------------------
    always_comb begin
        case (araddr)
            CSR_START_OFF:  rd_word.raw = AXI_DATA_WIDTH'(cfg.start);
            CSR_INFO_OFF:   rd_word = info_word;
            CSR_WIDTH_OFF:  rd_word.raw = AXI_DATA_WIDTH'(cfg.width);
            CSR_HEIGHT_OFF: rd_word.raw = AXI_DATA_WIDTH'(cfg.height);
            default:        rd_word.raw = '0;     // Clear and unmapped read zero
        endcase
    end

    always_ff @(posedge axi_clk) begin
        if (ar_fire) begin
            rdata <= rd_word;
        end
    end

    // ------------------------------------------------------------
    // Register writes and responses
    // ------------------------------------------------------------
    always_ff @(posedge axi_clk) begin
        if (!axi_reset_n) begin
            cfg        <= '0;
            clear_pend <= 1'b0;
            bvalid     <= 1'b0;
            rvalid     <= 1'b0;
        end else begin
            clear_pend <= wr_fire && (awaddr == CSR_CLEAR_OFF) && wdata[0];
            if (clear_pend) begin
                cfg <= '0;
            end else if (wr_fire) begin
                case (awaddr)
                    CSR_START_OFF:  cfg.start  <= wdata[0];
                    CSR_WIDTH_OFF:  cfg.width  <= wdata[CFG_DIM_WIDTH-1:0];
                    CSR_HEIGHT_OFF: cfg.height <= wdata[CFG_DIM_WIDTH-1:0];
                    default:        cfg        <= cfg;   // Info word is fixed
                endcase
            end
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (ar_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // A write response always follows a completed address and data handshake
    bvalid_after_write: assert property (
        @(posedge axi_clk) disable iff (!axi_reset_n)
        $rose(bvalid) |-> $past(awvalid && awready && wvalid && wready)
    );

endmodule

`default_nettype wire

// File: logic/pool_csr_pkg.sv
// Control port definitions for the average-pooling engine
// Register offsets, bus widths and the register word layouts
`default_nettype none

package pool_csr_pkg;

    // ------------------------------------------------------------
    // Bus widths
    // ------------------------------------------------------------
    localparam int AXI_DATA_WIDTH = 32;     // Control and stream word
    localparam int AXI_ADDR_WIDTH = 10;
    localparam int CFG_DIM_WIDTH  = 16;     // Image width and height fields

    // ------------------------------------------------------------
    // Register map, byte offsets
    // ------------------------------------------------------------
    localparam logic [AXI_ADDR_WIDTH-1:0] CSR_START_OFF  = 10'd0;
    localparam logic [AXI_ADDR_WIDTH-1:0] CSR_CLEAR_OFF  = 10'd4;
    localparam logic [AXI_ADDR_WIDTH-1:0] CSR_INFO_OFF   = 10'd8;   // Read only
    localparam logic [AXI_ADDR_WIDTH-1:0] CSR_WIDTH_OFF  = 10'd16;
    localparam logic [AXI_ADDR_WIDTH-1:0] CSR_HEIGHT_OFF = 10'd20;

    localparam logic [3:0] POOL_LAYER_KEY = 4'd1;   // Identifies an average pool layer

    // Info word, key sits in the low nibble
    typedef struct packed {
        logic [19:0] reserved;
        logic [3:0]  channels;
        logic [3:0]  kernel;
        logic [3:0]  key;
    } pool_info_t;

    // One register word, raw or decoded as the info layout
    typedef union packed {
        logic [AXI_DATA_WIDTH-1:0] raw;
        pool_info_t                info;
    } csr_word_u;

    // Configuration handed to the datapath
    typedef struct packed {
        logic                     start;
        logic [CFG_DIM_WIDTH-1:0] width;
        logic [CFG_DIM_WIDTH-1:0] height;
    } pool_cfg_t;

endpackage

`default_nettype wire

// File: logic/pool_data_pkg.sv
// Datapath types for the average-pooling engine
// Pixel words, the output stream beat and the sequencer states
`default_nettype none

package pool_data_pkg;

    import pool_csr_pkg::*;

    // One channel value of one pixel
    typedef logic [AXI_DATA_WIDTH-1:0] pixel_word_t;

    // Registered output beat
    typedef struct packed {
        pixel_word_t data;
        logic        last;      // Final word of the frame
    } stream_beat_t;

    // ------------------------------------------------------------
    // Sequencer states
    // ------------------------------------------------------------
    typedef enum logic [1:0] {
        SEQ_IDLE,       // Waiting for start
        SEQ_STREAM,     // Accepting pixels
        SEQ_DRAIN       // Frame input done, last window going out
    } seq_state_t;

endpackage

`default_nettype wire

// File: logic/pool_line_buffer.sv
// Row memories for the pooling window
// Each written pixel channel yields its vertical column of KERNEL_SIZE values
`timescale 1ns/1ns
`default_nettype none

module pool_line_buffer
    import pool_csr_pkg::*, pool_data_pkg::*;
#(
    parameter int KERNEL_SIZE = 3,
    parameter int CHANNELS    = 3,
    parameter int MAX_WIDTH   = 64,
    localparam int X_W  = $clog2(MAX_WIDTH),
    localparam int CH_W = (CHANNELS > 1) ? $clog2(CHANNELS) : 1
) (
    input  wire                axi_clk,
    input  wire                axi_reset_n,
    input  pool_cfg_t          cfg,
    input  wire                pixel_write,
    input  wire  [X_W-1:0]     x,
    input  wire  [CH_W-1:0]    ch,
    input  pixel_word_t        data,
    input  wire                frame_clear,
    output pixel_word_t        column [CHANNELS][KERNEL_SIZE],
    output logic               column_valid
);

    // Row 0 is the oldest line, row KERNEL_SIZE-2 the line just above
    pixel_word_t row_mem [CHANNELS][KERNEL_SIZE-1][MAX_WIDTH];

    // ------------------------------------------------------------
    // Row memories and column capture
    // ------------------------------------------------------------
    always_ff @(posedge axi_clk) begin
        if (frame_clear) begin
            for (int c = 0; c < CHANNELS; c++) begin
                for (int r = 0; r < KERNEL_SIZE-1; r++) begin
                    for (int i = 0; i < MAX_WIDTH; i++) begin
                        row_mem[c][r][i] <= '0;
                    end
                end
            end
        end else if (pixel_write) begin
            for (int c = 0; c < CHANNELS; c++) begin
                if (ch == CH_W'(c)) begin
                    // Older rows out, column shifted up one line
                    for (int r = 0; r < KERNEL_SIZE-1; r++) begin
                        column[c][r] <= row_mem[c][r][x];
                    end
                    for (int r = 0; r < KERNEL_SIZE-2; r++) begin
                        row_mem[c][r][x] <= row_mem[c][r+1][x];
                    end
                    row_mem[c][KERNEL_SIZE-2][x] <= data;
                    column[c][KERNEL_SIZE-1]     <= data;   // Current row at the bottom
                end
            end
        end
    end

    // Column complete once the last channel of the pixel is in
    always_ff @(posedge axi_clk) begin
        if (!axi_reset_n) begin
            column_valid <= 1'b0;
        end else begin
            column_valid <= pixel_write && !frame_clear && (ch == CH_W'(CHANNELS-1));
        end
    end

    // Writes never run past the configured row length
    x_inside_row: assert property (
        @(posedge axi_clk) disable iff (!axi_reset_n)
        pixel_write |-> (x < cfg.width)
    );

endmodule

`default_nettype wire

// File: logic/pool_sequencer.sv
// Frame sequencing for the pooling engine
// Counts channel, column and row, gates input and serializes results out
`timescale 1ns/1ns
`default_nettype none

module pool_sequencer
    import pool_csr_pkg::*, pool_data_pkg::*;
#(
    parameter int KERNEL_SIZE = 3,
    parameter int CHANNELS    = 3,
    parameter int MAX_WIDTH   = 64,
    localparam int X_W  = $clog2(MAX_WIDTH),
    localparam int CH_W = (CHANNELS > 1) ? $clog2(CHANNELS) : 1
) (
    input  wire               axi_clk,
    input  wire               axi_reset_n,
    input  pool_cfg_t         cfg,
    input  wire               s_axis_valid,
    output logic              s_axis_ready,
    output logic              pixel_write,
    output logic [X_W-1:0]    x,
    output logic [CH_W-1:0]   ch,
    output logic              frame_clear,
    output logic              window_ready,
    input  pixel_word_t       result [CHANNELS],
    input  wire               result_valid,
    output logic              m_axis_valid,
    input  wire               m_axis_ready,
    output stream_beat_t      out_beat
);

    localparam int OI_W = $clog2(CHANNELS + 1);

    seq_state_t               state;
    logic [CFG_DIM_WIDTH-1:0] y;
    logic                     last_ch;
    logic                     row_end;
    logic                     frame_end;
    logic                     final_win;    // Window in flight is the frame's last
    logic [OI_W-1:0]          out_idx;      // Next word to present
    pixel_word_t              hold [CHANNELS];

    // One window at a time through the pipeline and output stage
    // No input while the line buffers flush
    assign s_axis_ready = cfg.start && (state == SEQ_STREAM) && !m_axis_valid
                          && !window_ready && !result_valid && !frame_clear;
    assign pixel_write  = s_axis_valid && s_axis_ready;
    assign last_ch      = (ch == CH_W'(CHANNELS-1));
    assign row_end      = (x == cfg.width - 1'b1);
    assign frame_end    = row_end && (y == cfg.height - 1'b1);

    // ------------------------------------------------------------
    // State machine and position counters
    // ------------------------------------------------------------
    always_ff @(posedge axi_clk) begin
        if (!axi_reset_n) begin
            state        <= SEQ_IDLE;
            ch           <= '0;
            x            <= '0;
            y            <= '0;
            final_win    <= 1'b0;
            frame_clear  <= 1'b0;
            window_ready <= 1'b0;
        end else begin
            frame_clear  <= 1'b0;
            // Lines up with column_valid from the line buffer
            window_ready <= pixel_write && last_ch && (x >= X_W'(KERNEL_SIZE-1))
                            && (y >= CFG_DIM_WIDTH'(KERNEL_SIZE-1));
            case (state)
                SEQ_IDLE: begin
                    ch <= '0;
                    x  <= '0;
                    y  <= '0;
                    if (cfg.start) state <= SEQ_STREAM;
                end
                SEQ_STREAM: begin
                    if (!cfg.start) begin
                        state <= SEQ_IDLE;      // Soft clear drops start
                    end else if (pixel_write) begin
                        if (!last_ch) begin
                            ch <= ch + 1'b1;
                        end else begin
                            ch <= '0;
                            x  <= row_end ? '0 : x + 1'b1;
                            if (row_end) y <= frame_end ? '0 : y + 1'b1;
                            if (frame_end) begin
                                state     <= SEQ_DRAIN;
                                final_win <= 1'b1;
                            end
                        end
                    end
                end
                SEQ_DRAIN: begin
                    if (m_axis_valid && m_axis_ready && out_beat.last) begin
                        state       <= SEQ_STREAM;
                        final_win   <= 1'b0;
                        frame_clear <= 1'b1;    // Flush line buffers for the next frame
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Output holding stage
    // ------------------------------------------------------------
    always_ff @(posedge axi_clk) begin
        if (result_valid) begin
            hold <= result;
        end
    end

    always_ff @(posedge axi_clk) begin
        if (!axi_reset_n) begin
            m_axis_valid <= 1'b0;
            out_beat     <= '0;
            out_idx      <= '0;
        end else if (result_valid) begin
            m_axis_valid  <= 1'b1;      // First channel straight from the sum register
            out_beat.data <= result[0];
            out_beat.last <= final_win && (CHANNELS == 1);
            out_idx       <= OI_W'(1);
        end else if (m_axis_valid && m_axis_ready) begin
            if (out_idx == OI_W'(CHANNELS)) begin
                m_axis_valid  <= 1'b0;
                out_beat.last <= 1'b0;
            end else begin
                out_beat.data <= hold[out_idx];
                out_beat.last <= final_win && (out_idx == OI_W'(CHANNELS-1));
                out_idx       <= out_idx + 1'b1;
            end
        end
    end

    // Stalled beat stays put until taken
    out_beat_stable: assert property (
        @(posedge axi_clk) disable iff (!axi_reset_n)
        (m_axis_valid && !m_axis_ready) |=> (m_axis_valid && $stable(out_beat))
    );

endmodule

`default_nettype wire

// File: logic/window_average.sv
// Sliding KERNEL_SIZE x KERNEL_SIZE window per channel
// Sums the window and registers the floored average
`timescale 1ns/1ns
`default_nettype none

module window_average
    import pool_data_pkg::*;
#(
    parameter int KERNEL_SIZE = 3,
    parameter int CHANNELS    = 3
) (
    input  wire          axi_clk,
    input  wire          axi_reset_n,
    input  pixel_word_t  column [CHANNELS][KERNEL_SIZE],
    input  wire          column_valid,
    input  wire          window_ready,
    output pixel_word_t  result [CHANNELS],
    output logic         result_valid
);

    localparam int K_SQ  = KERNEL_SIZE * KERNEL_SIZE;
    localparam int SUM_W = $bits(pixel_word_t) + $clog2(K_SQ);  // No overflow on the sum

    // Previous KERNEL_SIZE-1 columns, index 0 oldest
    pixel_word_t      win [CHANNELS][KERNEL_SIZE-1][KERNEL_SIZE];
    logic [SUM_W-1:0] win_sum [CHANNELS];

    // ------------------------------------------------------------
    // Window shift
    // ------------------------------------------------------------
    always_ff @(posedge axi_clk) begin
        if (column_valid) begin
            for (int c = 0; c < CHANNELS; c++) begin
                for (int j = 0; j < KERNEL_SIZE-2; j++) begin
                    win[c][j] <= win[c][j+1];
                end
                win[c][KERNEL_SIZE-2] <= column[c];
            end
        end
    end

    // Full window sum, stored columns plus the arriving one
    always_comb begin
        for (int c = 0; c < CHANNELS; c++) begin
            win_sum[c] = '0;
            for (int k = 0; k < KERNEL_SIZE; k++) begin
                win_sum[c] = win_sum[c] + SUM_W'(column[c][k]);
                for (int j = 0; j < KERNEL_SIZE-1; j++) begin
                    win_sum[c] = win_sum[c] + SUM_W'(win[c][j][k]);
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Division and result register
    // ------------------------------------------------------------
    always_ff @(posedge axi_clk) begin
        if (column_valid && window_ready) begin
            for (int c = 0; c < CHANNELS; c++) begin
                result[c] <= pixel_word_t'(win_sum[c] / K_SQ);   // Floored
            end
        end
    end

    always_ff @(posedge axi_clk) begin
        if (!axi_reset_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= column_valid && window_ready;
        end
    end

endmodule

`default_nettype wire

// File: testbench/avg_pool_vectors.svh
// Frame tests for the average-pooling testbench
// One row per frame, applied in order by the main test loop
`ifndef AVG_POOL_VECTORS_SVH
`define AVG_POOL_VECTORS_SVH

// ------------------------------------------------------------
// Row layout
// ------------------------------------------------------------
typedef struct packed {
    int          width;         // Pixels per row
    int          height;        // Rows per frame
    int          seed_skip;     // $urandom draws skipped before the pixels
    logic        bp_mode;       // 1 gives random m_axis_ready
    logic [31:0] pix_mask;      // Limits the pixel value range
    int          exp_words;     // (width-2) x (height-2) x 3 output words
} frame_test_t;

localparam int NUM_TESTS = 6;

// Columns: width, height, seed skip, back-pressure, pixel mask, expected words
localparam frame_test_t TESTS [NUM_TESTS] = '{
    '{8,  6, 0,  1'b0, 32'hffff_ffff, 72},     // Full range, always ready
    '{5,  5, 3,  1'b1, 32'h0000_ffff, 27},
    '{12, 4, 7,  1'b0, 32'h0000_00ff, 60},     // Small values, wider row
    '{3,  3, 1,  1'b1, 32'hffff_ffff, 3},      // Single window
    '{64, 3, 11, 1'b1, 32'hffff_ffff, 186},    // Row at maximum length
    '{10, 7, 5,  1'b1, 32'h0fff_ffff, 120}
};

// Info word, key 1, kernel 3, channels 3
localparam pool_info_t EXP_INFO = '{
    reserved: 20'd0,
    channels: 4'd3,
    kernel:   4'd3,
    key:      4'd1
};

`endif

// File: testbench/avg_pool_tb.sv
// Testbench for the average-pooling engine
// Programs the control port, streams frames and checks averages against a model
`timescale 1ns/1ns
`default_nettype none

module avg_pool_tb
    import pool_csr_pkg::*;
();

    `include "avg_pool_vectors.svh"

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 16;
    localparam int KERNEL          = 3;
    localparam int CHANNELS        = 3;
    localparam int WATCHDOG_MARGIN = 2000;    // Register traffic and idle gaps

    logic                      axi_clk;
    logic                      axi_reset_n;
    logic [AXI_ADDR_WIDTH-1:0] awaddr;
    logic                      awvalid;
    logic                      awready;
    logic [AXI_DATA_WIDTH-1:0] wdata;
    logic                      wvalid;
    logic                      wready;
    logic                      bvalid;
    logic                      bready;
    logic [AXI_ADDR_WIDTH-1:0] araddr;
    logic                      arvalid;
    logic                      arready;
    logic [AXI_DATA_WIDTH-1:0] rdata;
    logic                      rvalid;
    logic                      rready;
    logic [AXI_DATA_WIDTH-1:0] s_axis_data;
    logic                      s_axis_valid;
    logic                      s_axis_ready;
    logic                      s_axis_last;
    logic [AXI_DATA_WIDTH-1:0] m_axis_data;
    logic                      m_axis_valid;
    logic                      m_axis_ready;
    logic                      m_axis_last;
    logic [3:0]                m_axis_keep;

    int          errors;
    int          checks;
    logic [31:0] pixels [$];      // Frame in arrival order, channel fastest
    logic [31:0] exp_data [$];    // Model output for the frame

    avg_pool_top avg_pool_top_i (
        .axi_clk, .axi_reset_n, .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bvalid, .bready, .araddr, .arvalid, .arready, .rdata, .rvalid, .rready,
        .s_axis_data, .s_axis_valid, .s_axis_ready, .s_axis_last,
        .m_axis_data, .m_axis_valid, .m_axis_ready, .m_axis_last, .m_axis_keep
    );

    // Run length from the table, 4 cycles per input word
    function automatic int watchdog_cycles();
        int total;
        total = 0;
        foreach (TESTS[i]) total += TESTS[i].width * TESTS[i].height;
        return total * CHANNELS * 4 + WATCHDOG_MARGIN;
    endfunction

    initial begin
        axi_clk = 1'b0;
        forever #(CLK_PERIOD/2) axi_clk = ~axi_clk;
    end

    initial begin
        repeat (watchdog_cycles()) @(posedge axi_clk);
        $display("Timeout: run did not finish within %0d clock cycles", watchdog_cycles());
        $display("Verification failed");
        $finish;
    end

    // ------------------------------------------------------------
    // Checks and bus tasks
    // ------------------------------------------------------------
    task automatic expect_equal(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERROR %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic write_reg(input logic [AXI_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
        @(negedge axi_clk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        do @(posedge axi_clk); while (!(awready && wready));
        @(negedge axi_clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        do @(posedge axi_clk); while (!bvalid);     // Response taken on this edge
        @(negedge axi_clk);
        bready = 1'b0;
    endtask

    task automatic read_reg(input logic [AXI_ADDR_WIDTH-1:0] addr, output logic [31:0] data);
        @(negedge axi_clk);
        araddr  = addr;
        arvalid = 1'b1;
        do @(posedge axi_clk); while (!arready);
        @(negedge axi_clk);
        arvalid = 1'b0;
        rready  = 1'b1;
        do @(posedge axi_clk); while (!rvalid);
        data = rdata;
        @(negedge axi_clk);
        rready = 1'b0;
    endtask

    // Floored mean of each KERNEL x KERNEL window, row major, channel fastest
    function automatic void build_expected(input int width, input int height);
        longint unsigned sum;
        exp_data.delete();
        for (int wy = KERNEL-1; wy < height; wy++) begin
            for (int wx = KERNEL-1; wx < width; wx++) begin
                for (int c = 0; c < CHANNELS; c++) begin
                    sum = 0;
                    for (int dy = 0; dy < KERNEL; dy++) begin
                        for (int dx = 0; dx < KERNEL; dx++) begin
                            sum += pixels[((wy-dy)*width + (wx-dx))*CHANNELS + c];
                        end
                    end
                    exp_data.push_back(32'(sum / (KERNEL*KERNEL)));
                end
            end
        end
    endfunction

    // ------------------------------------------------------------
    // One frame from the table
    // ------------------------------------------------------------
    task automatic run_frame(input frame_test_t t);
        int          in_idx;
        int          out_idx;
        int          n_in;
        logic        stalled;         // Beat offered but not taken last edge
        logic [31:0] stall_data;
        logic        stall_last;
        logic [31:0] rd;
        in_idx     = 0;
        out_idx    = 0;
        stalled    = 1'b0;
        stall_data = '0;
        stall_last = 1'b0;
        n_in       = t.width * t.height * CHANNELS;
        write_reg(CSR_WIDTH_OFF, t.width);
        write_reg(CSR_HEIGHT_OFF, t.height);
        write_reg(CSR_START_OFF, 32'd1);
        read_reg(CSR_WIDTH_OFF, rd);
        expect_equal("width register", rd, t.width);
        read_reg(CSR_HEIGHT_OFF, rd);
        expect_equal("height register", rd, t.height);
        read_reg(CSR_START_OFF, rd);
        expect_equal("start register", rd, 32'd1);
        pixels.delete();
        repeat (t.seed_skip) void'($urandom);
        repeat (n_in) pixels.push_back($urandom & t.pix_mask);
        build_expected(t.width, t.height);
        expect_equal("model word count", exp_data.size(), t.exp_words);
        while (out_idx < exp_data.size()) begin
            @(negedge axi_clk);
            s_axis_valid = (in_idx < n_in);           // Same word again until taken
            s_axis_data  = (in_idx < n_in) ? pixels[in_idx] : '0;
            s_axis_last  = (in_idx == n_in - 1);
            m_axis_ready = t.bp_mode ? 1'($urandom) : 1'b1;
            @(posedge axi_clk);
            if (stalled) begin
                checks++;
                assert (m_axis_valid && m_axis_data === stall_data
                        && m_axis_last === stall_last) else begin
                    errors++;
                    $display("ERROR %0t ns: output beat changed while stalled", $time);
                end
            end
            stalled    = m_axis_valid && !m_axis_ready;
            stall_data = m_axis_data;
            stall_last = m_axis_last;
            if (s_axis_valid && s_axis_ready) in_idx++;
            if (m_axis_valid && m_axis_ready) begin
                expect_equal($sformatf("output word %0d", out_idx), m_axis_data,
                             exp_data[out_idx]);
                expect_equal($sformatf("last flag of word %0d", out_idx), m_axis_last,
                             out_idx == exp_data.size() - 1);
                out_idx++;
            end
        end
        @(negedge axi_clk);
        s_axis_valid = 1'b0;
        s_axis_last  = 1'b0;
        m_axis_ready = 1'b1;
        repeat (8) begin                            // Nothing after the last word
            @(posedge axi_clk);
            checks++;
            assert (!m_axis_valid) else begin
                errors++;
                $display("ERROR %0t ns: output word beyond the end of the frame", $time);
            end
        end
        @(negedge axi_clk);
        m_axis_ready = 1'b0;
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        logic [31:0] rd;
        csr_word_u   info;
        void'($urandom(32'hce2d));
        errors       = 0;
        checks       = 0;
        axi_reset_n  = 1'b0;
        awaddr       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wvalid       = 1'b0;
        bready       = 1'b0;
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        s_axis_data  = '0;
        s_axis_valid = 1'b0;
        s_axis_last  = 1'b0;
        m_axis_ready = 1'b0;
        repeat (RESET_CYCLES) @(posedge axi_clk);
        @(negedge axi_clk);
        axi_reset_n = 1'b1;
        @(negedge axi_clk);
        // s_ready, m_valid, m_last, bvalid, rvalid low, awready and arready high
        expect_equal("outputs after reset", {s_axis_ready, m_axis_valid, m_axis_last,
                     bvalid, rvalid, awready, arready}, 7'b0000011);
        expect_equal("m_axis_keep", m_axis_keep, 4'hf);
        read_reg(CSR_INFO_OFF, rd);
        info.raw = rd;
        expect_equal("info key", info.info.key, EXP_INFO.key);
        expect_equal("info kernel", info.info.kernel, EXP_INFO.kernel);
        expect_equal("info channels", info.info.channels, EXP_INFO.channels);
        write_reg(CSR_INFO_OFF, 32'hffff_ffff);     // Read only, must be ignored
        read_reg(CSR_INFO_OFF, rd);
        expect_equal("info after write", rd, EXP_INFO);
        foreach (TESTS[i]) run_frame(TESTS[i]);
        write_reg(CSR_CLEAR_OFF, 32'd1);
        read_reg(CSR_START_OFF, rd);
        expect_equal("start after clear", rd, 32'd0);
        read_reg(CSR_WIDTH_OFF, rd);
        expect_equal("width after clear", rd, 32'd0);
        read_reg(CSR_HEIGHT_OFF, rd);
        expect_equal("height after clear", rd, 32'd0);
        @(negedge axi_clk);
        s_axis_valid = 1'b1;
        s_axis_data  = $urandom;
        repeat (10) begin
            @(posedge axi_clk);
            checks++;
            assert (!s_axis_ready) else begin
                errors++;
                $display("ERROR %0t ns: s_axis_ready high after soft clear", $time);
            end
        end
        @(negedge axi_clk);
        s_axis_valid = 1'b0;
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
